// File: cpu.f
+incdir+source
source/cpu_pkg.sv
source/decode.sv
source/reg_file.sv
source/execute.sv
source/cpu.sv
tests/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f cpu.f --top-module cpu_tb -Mdir "$OBJ" -o cpu_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ/cpu_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// File: tests/cpu_testdata.txt
# name  gap  instr(hex)  wb_en  wb_sel(dec)  wb_data(hex)
# gap 1 allows 0..2 random idle cycles before the instruction
zero_read     0 004A6000 1 1  00000000
addi_pos      0 80800064 1 2  00000064
addi_neg      0 80C1FFF9 1 3  FFFFFFF9
addi_big      0 8100FFFF 1 4  0000FFFF
addi_min      0 81410000 1 5  FFFF0000
add_rr        0 01843000 1 6  0000005D
sub_wrap      0 09C22000 1 7  FFFFFF9C
and_rr        0 12064000 1 8  0000FFF9
or_rr         0 1A485000 1 9  FFFFFFFF
xor_rr        0 22865000 1 10 0000FFF9
sll_rr        0 2AC62000 1 11 FFFFFF90
srl_rr        0 330A2000 1 12 0FFFF000
sra_rr        0 3B4A2000 1 13 FFFFF000
subi_neg      0 8B85FFFB 1 14 00000069
ori_neg       0 9C05FF00 1 16 FFFFFF64
slli          0 AC840008 1 18 00006400
srai          0 BD060001 1 20 FFFFFFFC
chain_a       0 8540000A 1 21 0000000A
chain_fwd     0 05AB5000 1 22 00000014
chain_mix     0 0DED5000 1 23 0000000A
chain_wt      0 A56C0003 1 21 00000017
chain_both    0 2E2B7000 1 24 00005C00
rd_zero       0 80000055 0 0  00000000
x0_after      0 9E400000 1 25 00000000
undef_op      0 46842000 0 0  00000000
undef_imm     0 C6840001 0 0  00000000
x26_unwritten 0 06C1A000 1 27 00000000
gap_add       1 07044000 1 28 00010063
gap_sub       1 0F485000 1 29 0001FFFF
gap_srai      1 BF8A0010 1 30 FFFFFFFF
gap_read      1 00780000 1 1  00010063

// File: tests/cpu_tb.sv
`include "cpu_defines.svh"

module cpu_tb;

    import cpu_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int LATENCY    = 2;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic [`CPU_WORD_W-1:0] instr;
    logic                   wb_en;
    logic [`CPU_SEL_W-1:0]  wb_sel;
    logic [`CPU_WORD_W-1:0] wb_data;

    // test table with one entry per data line
    string                  name_q  [$];
    int                     gap_q   [$];
    logic [`CPU_WORD_W-1:0] instr_q [$];
    int                     en_q    [$];
    int                     sel_q   [$];
    logic [`CPU_WORD_W-1:0] data_q  [$];

    // due cycle and table index of each pending check
    int   due_q [$];
    int   idx_q [$];
    int   cycle       = 0;
    int   errors      = 0;
    int   checks      = 0;
    logic table_ready = 1'b0;

    cpu u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_en       (wb_en),
        .wb_sel      (wb_sel),
        .wb_data     (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("CHECK FAILED %0s %0s: expected %h actual %h", test, what, expected, actual);
        end
    endtask

    // print the failing word through the format its opcode selects
    task automatic describe_instr(input logic [31:0] word);
        instr_u u;
        u = word;
        if (u.r.op[4]) begin
            $display("  I-format op %0d rd %0d rs1 %0d imm %0d", u.i.op, u.i.rd, u.i.rs1, u.i.imm);
        end else begin
            $display("  R-format op %0d rd %0d rs1 %0d rs2 %0d", u.r.op, u.r.rd, u.r.rs1, u.r.rs2);
        end
    endtask

    task automatic load_table();
        int           fd;
        int           got;
        string        line;
        logic [127:0] name_v;
        int           gap_v;
        logic [31:0]  instr_v;
        int           en_v;
        int           sel_v;
        logic [31:0]  data_v;
        fd = $fopen("tests/cpu_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open tests/cpu_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                // skip column notes and blank lines
                if (line.len() < 2 || line[0] == "#") continue;
                got = $sscanf(line, "%s %d %h %d %d %h",
                              name_v, gap_v, instr_v, en_v, sel_v, data_v);
                if (got != 6) begin
                    errors++;
                    $display("data line could not be parsed: %0s", line);
                end else begin
                    name_q.push_back($sformatf("%0s", name_v));
                    gap_q.push_back(gap_v);
                    instr_q.push_back(instr_v);
                    en_q.push_back(en_v);
                    sel_q.push_back(sel_v);
                    data_q.push_back(data_v);
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        int idle;
        void'($urandom(32'h39dd4728));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        load_table();
        table_ready = 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int k = 0; k < instr_q.size(); k++) begin
            if (gap_q[k] != 0) begin
                idle = $urandom % 3;
                repeat (idle) begin
                    instr_valid <= 1'b0;
                    instr       <= '0;
                    @(posedge clk);
                end
            end
            instr_valid <= 1'b1;
            instr       <= instr_q[k];
            // cycle still holds the pre-edge count here
            // and the checker sees it one higher after this edge
            due_q.push_back(cycle + 1 + LATENCY);
            idx_q.push_back(k);
            @(posedge clk);
        end
        instr_valid <= 1'b0;
        instr       <= '0;
        while (due_q.size() != 0) @(posedge clk);
        // wb_en must stay low over a few idle cycles
        repeat (3) @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // checker sampling mid-cycle where wb_* is stable
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        int idx;
        int errors_before;
        if (rst_n) begin
            errors_before = errors;
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                idx = idx_q.pop_front();
                void'(due_q.pop_front());
                check_value(name_q[idx], "wb_en", en_q[idx], 32'(wb_en));
                if (en_q[idx] != 0) begin
                    check_value(name_q[idx], "wb_sel", sel_q[idx], 32'(wb_sel));
                    check_value(name_q[idx], "wb_data", data_q[idx], wb_data);
                end
                if (errors != errors_before) describe_instr(instr_q[idx]);
            end else begin
                // no write allowed while nothing is due
                check_value("idle", "wb_en", 32'd0, 32'(wb_en));
            end
        end
    end

    // watchdog sized from the table length
    initial begin
        int limit;
        wait (table_ready);
        limit = instr_q.size() * 4 + 20;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: source/cpu.sv
`include "cpu_defines.svh"

module cpu (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   instr_valid,
    input  logic [`CPU_WORD_W-1:0] instr,
    output logic                   wb_en,
    output logic [`CPU_SEL_W-1:0]  wb_sel,
    output logic [`CPU_WORD_W-1:0] wb_data
);

    import cpu_pkg::*;

    // decode <-> reg file
    logic [`CPU_SEL_W-1:0]  rs1_sel;
    logic [`CPU_SEL_W-1:0]  rs2_sel;
    logic [`CPU_WORD_W-1:0] rs1_data;
    logic [`CPU_WORD_W-1:0] rs2_data;

    // decode -> execute
    logic                   issue;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic [`CPU_WORD_W-1:0] imm;
    logic [`CPU_SEL_W-1:0]  rd_sel;

    //////////////////////////////////////////////////////////////////////
    // producer: decode
    //////////////////////////////////////////////////////////////////////

    decode u_decode (
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .issue       (issue),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm         (imm),
        .rd_sel      (rd_sel)
    );

    //////////////////////////////////////////////////////////////////////
    // buffer: register file, written from writeback
    //////////////////////////////////////////////////////////////////////

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////////////////////////
    // consumer: execute, wb_* doubles as the result ports
    //////////////////////////////////////////////////////////////////////

    execute u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .imm      (imm),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_sel   (rd_sel),
        .wb_en    (wb_en),
        .wb_sel   (wb_sel),
        .wb_data  (wb_data)
    );

endmodule

// File: source/execute.sv
`include "cpu_defines.svh"

module execute (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   issue,
    input  cpu_pkg::alu_op_e       alu_op,
    input  logic                   use_imm,
    input  logic [`CPU_WORD_W-1:0] imm,
    input  logic [`CPU_SEL_W-1:0]  rs1_sel,
    input  logic [`CPU_SEL_W-1:0]  rs2_sel,
    input  logic [`CPU_WORD_W-1:0] rs1_data,
    input  logic [`CPU_WORD_W-1:0] rs2_data,
    input  logic [`CPU_SEL_W-1:0]  rd_sel,
    output logic                   wb_en,
    output logic [`CPU_SEL_W-1:0]  wb_sel,
    output logic [`CPU_WORD_W-1:0] wb_data
);

    import cpu_pkg::*;

    // shift amount comes from the low bits of operand 2
    localparam int SHAMT_W = $clog2(`CPU_WORD_W);

    // input register
    logic                   issue_q;
    alu_op_e                alu_op_q;
    logic                   use_imm_q;
    logic [`CPU_WORD_W-1:0] imm_q;
    logic [`CPU_SEL_W-1:0]  rs1_sel_q;
    logic [`CPU_SEL_W-1:0]  rs2_sel_q;
    logic [`CPU_WORD_W-1:0] rs1_data_q;
    logic [`CPU_WORD_W-1:0] rs2_data_q;
    logic [`CPU_SEL_W-1:0]  rd_sel_q;

    // operand path
    logic                   forward1_sel;
    logic                   forward2_sel;
    logic [`CPU_WORD_W-1:0] op_a;
    logic [`CPU_WORD_W-1:0] reg_b;
    logic [`CPU_WORD_W-1:0] op_b;
    logic [SHAMT_W-1:0]     shamt;
    logic [`CPU_WORD_W-1:0] alu_out;

    //////////////////////////////////////////////////////////////////////
    // input register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_q <= 1'b0;
        end else begin
            issue_q <= issue;
        end
    end

    // payload, captured every cycle, qualified by issue_q
    always_ff @(posedge clk) begin
        alu_op_q   <= alu_op;
        use_imm_q  <= use_imm;
        imm_q      <= imm;
        rs1_sel_q  <= rs1_sel;
        rs2_sel_q  <= rs2_sel;
        rs1_data_q <= rs1_data;
        rs2_data_q <= rs2_data;
        rd_sel_q   <= rd_sel;
    end

    //////////////////////////////////////////////////////////////////////
    // forwarding and operand select
    //////////////////////////////////////////////////////////////////////

    // previous instruction still sitting in the writeback register
    // its value never made it into rs*_data_q, take it from wb_data
    assign forward1_sel = wb_en && (wb_sel == rs1_sel_q);
    assign forward2_sel = wb_en && (wb_sel == rs2_sel_q);

    assign op_a  = forward1_sel ? wb_data : rs1_data_q;
    assign reg_b = forward2_sel ? wb_data : rs2_data_q;

    // ALU_src: immediate or second register
    assign op_b  = use_imm_q ? imm_q : reg_b;
    assign shamt = op_b[SHAMT_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op_q)
            OP_ADD, OP_ADDI: alu_out = op_a + op_b;
            OP_SUB, OP_SUBI: alu_out = op_a - op_b;
            OP_AND, OP_ANDI: alu_out = op_a & op_b;
            OP_OR,  OP_ORI:  alu_out = op_a | op_b;
            OP_XOR, OP_XORI: alu_out = op_a ^ op_b;
            OP_SLL, OP_SLLI: alu_out = op_a << shamt;
            OP_SRL, OP_SRLI: alu_out = op_a >> shamt;
            // arithmetic shift, fills with the sign bit
            OP_SRA, OP_SRAI: alu_out = $signed(op_a) >>> shamt;
            default:         alu_out = '0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // writeback register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else begin
            wb_en <= issue_q;
        end
    end

    // hold last result when idle
    always_ff @(posedge clk) begin
        if (issue_q) begin
            wb_sel  <= rd_sel_q;
            wb_data <= alu_out;
        end
    end

    // feeds both the forward compare and the reg file write
    a_wb_en_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(wb_en)
    ) else $error("execute: wb_en unknown after reset");

endmodule

// File: source/reg_file.sv
`include "cpu_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CPU_SEL_W-1:0]  rs1_sel,
    input  logic [`CPU_SEL_W-1:0]  rs2_sel,
    input  logic                   wb_en,
    input  logic [`CPU_SEL_W-1:0]  wb_sel,
    input  logic [`CPU_WORD_W-1:0] wb_data,
    output logic [`CPU_WORD_W-1:0] rs1_data,
    output logic [`CPU_WORD_W-1:0] rs2_data
);

    logic [`CPU_WORD_W-1:0] regs [`CPU_REG_COUNT];

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    // everything cleared on reset, x0 included
    // x0 stays zero since writes never target it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_sel] <= wb_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////////////////////////

    // write-through: a read of the register being written this cycle
    // sees the new value, covers the distance-2 dependency
    assign rs1_data = (wb_en && wb_sel == rs1_sel) ? wb_data : regs[rs1_sel];
    assign rs2_data = (wb_en && wb_sel == rs2_sel) ? wb_data : regs[rs2_sel];

    // decode filters rd 0 through issue, nothing here should see it
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_en |-> (wb_sel != '0)
    ) else $error("reg_file: write to register 0");

endmodule

// File: source/decode.sv
`include "cpu_defines.svh"

module decode (
    input  logic                   instr_valid,
    input  cpu_pkg::instr_u        instr,
    input  logic [`CPU_WORD_W-1:0] rs1_data,
    input  logic [`CPU_WORD_W-1:0] rs2_data,
    output logic [`CPU_SEL_W-1:0]  rs1_sel,
    output logic [`CPU_SEL_W-1:0]  rs2_sel,
    output logic                   issue,
    output cpu_pkg::alu_op_e       alu_op,
    output logic                   use_imm,
    output logic [`CPU_WORD_W-1:0] imm,
    output logic [`CPU_SEL_W-1:0]  rd_sel
);

    import cpu_pkg::*;

    // sign fill width for the I-format immediate
    localparam int IMM_EXT_W = `CPU_WORD_W - `CPU_IMM_W;

    logic op_defined;

    //////////////////////////////////////////////////////////////////////
    // opcode and format select
    //////////////////////////////////////////////////////////////////////

    // op, rd and rs1 sit in the same place in both views
    assign alu_op  = instr.r.op;

    // bit 4 set selects the immediate form and operand 2 from imm
    assign use_imm = instr.r.op[4];

    // defined codes are 0..7 and 16..23, so bit 3 must be clear
    assign op_defined = ~instr.r.op[3];

    //////////////////////////////////////////////////////////////////////
    // register selects
    //////////////////////////////////////////////////////////////////////

    assign rs1_sel = instr.r.rs1;
    assign rd_sel  = instr.r.rd;

    // I-format has no rs2 so it parks on x0 and never forwards
    assign rs2_sel = use_imm ? '0 : instr.r.rs2;

    //////////////////////////////////////////////////////////////////////
    // immediate
    //////////////////////////////////////////////////////////////////////

    // sign extend the 17-bit field from the I view
    // held at zero for R-format where it is unused
    always_comb begin
        if (use_imm) begin
            imm = {{IMM_EXT_W{instr.i.imm[`CPU_IMM_W-1]}}, instr.i.imm};
        end else begin
            imm = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // issue
    //////////////////////////////////////////////////////////////////////

    // only a strobed, defined word with a real destination writes
    // rd 0 and bad opcodes just fall out of the pipe here
    assign issue = instr_valid & op_defined & (instr.r.rd != '0);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a strobed word must be fully known
    always_comb begin
        if (instr_valid) begin
            a_instr_known: assert (!$isunknown(instr))
                else $error("decode: instr unknown while instr_valid high");
        end
    end

    // x0 must read back zero from the register file
    // including the write-through path
    always_comb begin
        if (issue && rs1_sel == '0) begin
            a_rs1_zero: assert (rs1_data == '0)
                else $error("decode: register 0 read nonzero on rs1");
        end
        if (issue && !use_imm && rs2_sel == '0) begin
            a_rs2_zero: assert (rs2_data == '0)
                else $error("decode: register 0 read nonzero on rs2");
        end
    end

endmodule

// File: source/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    // low three bits pick the operation, bit 4 picks the immediate form
    // values 8..15 and 24..31 are undefined
    typedef enum logic [`CPU_OP_W-1:0] {
        OP_ADD  = 5'd0,
        OP_SUB  = 5'd1,
        OP_AND  = 5'd2,
        OP_OR   = 5'd3,
        OP_XOR  = 5'd4,
        OP_SLL  = 5'd5,
        OP_SRL  = 5'd6,
        OP_SRA  = 5'd7,
        OP_ADDI = 5'd16,
        OP_SUBI = 5'd17,
        OP_ANDI = 5'd18,
        OP_ORI  = 5'd19,
        OP_XORI = 5'd20,
        OP_SLLI = 5'd21,
        OP_SRLI = 5'd22,
        OP_SRAI = 5'd23
    } alu_op_e;

    // register-register word, low 12 bits unused
    typedef struct packed {
        alu_op_e                op;
        logic [`CPU_SEL_W-1:0]  rd;
        logic [`CPU_SEL_W-1:0]  rs1;
        logic [`CPU_SEL_W-1:0]  rs2;
        logic [11:0]            pad;
    } instr_r_t;

    // register-immediate word, same op/rd/rs1 placement
    typedef struct packed {
        alu_op_e                     op;
        logic [`CPU_SEL_W-1:0]       rd;
        logic [`CPU_SEL_W-1:0]       rs1;
        logic signed [`CPU_IMM_W-1:0] imm;
    } instr_i_t;

    // one fetched word, two views
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

// File: source/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and instruction word width
`define CPU_WORD_W 32

// architectural register count
`define CPU_REG_COUNT 32

// register select width, log2 of the register count
`define CPU_SEL_W 5

// opcode field width, bit 4 marks the immediate form
`define CPU_OP_W 5

// signed immediate field of the I-format word
`define CPU_IMM_W 17

`endif
